// File: Makefile
SIM    := verilator
FLAGS  := --binary --timing -Wno-fatal
TOP    := frame_buffer_tb
FLIST  := list.f
OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
LOG    := sim.log
SRCS   := $(wildcard *.sv *.svh)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@grep -q "^Everything OK$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: fb_arbiter.sv
/*
  SRAM access arbiter
  Priority of reads over ADC pixels over SPI pixels with one command per cycle
  Times read return and blanks reads outside the view
*/
`default_nettype none
`include "fb_macros.svh"

module fb_arbiter (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    frozen,
    input  wire                    read_valid,
    input  wire fb_pkg::read_req_t read_req,
    input  wire                    adc_not_empty,
    input  wire                    spi_not_empty,
    input  wire fb_pkg::pixel_wr_t adc_head,
    input  wire fb_pkg::pixel_wr_t spi_head,
    output logic                   adc_pop,
    output logic                   spi_pop,
    output logic                   cmd_valid,
    output fb_pkg::sram_cmd_t      cmd,
    input  wire fb_pkg::sram_word_t rd_word,
    output logic                   read_data_valid,
    output fb_pkg::pixel_t         read_data
);

    localparam int LAT = `FB_READ_LATENCY;

    logic              read_in_view;
    logic              adc_in_view;
    logic              spi_in_view;
    logic              cmd_take;
    fb_pkg::sram_cmd_t cmd_next;
    // Bit 0 is the newest read
    logic [LAT-1:0]    rd_pipe;
    logic [LAT-1:0]    blank_pipe;

    // SRAM word address with 10 bits of x above 10 bits of y
    function automatic fb_pkg::sram_addr_t pack_addr(input fb_pkg::coord_t x,
                                                     input fb_pkg::coord_t y);
        return {x[9:0], y[9:0]};
    endfunction

    assign read_in_view = (read_req.x < `FB_X_RES) && (read_req.y < `FB_Y_RES);
    assign adc_in_view  = (adc_head.x < `FB_X_RES) && (adc_head.y < `FB_Y_RES);
    assign spi_in_view  = (spi_head.x < `FB_X_RES) && (spi_head.y < `FB_Y_RES);

    // ADC head is consumed when chosen even while frozen
    assign adc_pop = !read_valid && adc_not_empty;
    // SPI only gets the slot when ADC has nothing
    assign spi_pop = !read_valid && !adc_not_empty && spi_not_empty;

    // Priority choice
    always_comb begin
        cmd_take       = 1'b0;
        cmd_next.addr  = pack_addr(read_req.x, read_req.y);
        cmd_next.write = 1'b0;
        cmd_next.data  = '0;
        if (read_valid) begin
            // Blank reads never reach the SRAM
            cmd_take = read_in_view;
        end else if (adc_not_empty) begin
            cmd_take       = adc_in_view && !frozen;
            cmd_next.addr  = pack_addr(adc_head.x, adc_head.y);
            cmd_next.write = 1'b1;
            cmd_next.data  = {2'b00, adc_head.pixel};
        end else if (spi_not_empty) begin
            cmd_take       = spi_in_view;
            cmd_next.addr  = pack_addr(spi_head.x, spi_head.y);
            cmd_next.write = 1'b1;
            cmd_next.data  = {2'b00, spi_head.pixel};
        end
    end

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_valid       <= 1'b0;
            rd_pipe         <= '0;
            read_data_valid <= 1'b0;
        end else begin
            cmd_valid       <= cmd_take;
            rd_pipe         <= {rd_pipe[LAT-2:0], read_valid};
            read_data_valid <= rd_pipe[LAT-1];
        end
    end

    // Command payload and read return data
    always_ff @(posedge clk) begin
        cmd        <= cmd_next;
        blank_pipe <= {blank_pipe[LAT-2:0], read_valid && !read_in_view};
        if (blank_pipe[LAT-1]) begin
            read_data <= '0;
        end else begin
            read_data <= rd_word[15:0];
        end
    end

endmodule

`default_nettype wire

// File: fb_macros.svh
/*
  Frame buffer build constants
  View size, pixel FIFO depth and the SRAM and read-return timing
*/
`ifndef FB_MACROS_SVH
`define FB_MACROS_SVH

// Visible window, pixels outside are never stored
`define FB_X_RES 800
`define FB_Y_RES 600

// Entries per pixel FIFO, power of two
`define FB_FIFO_DEPTH 16

// Edges from a sampled read request to read_data_valid
`define FB_READ_LATENCY 5

// Cycles from address on the pins to the data phase on the bus
`define FB_SRAM_PIPE 2

`endif

// File: fb_pkg.sv
/*
  Frame buffer types
  Coordinate, pixel and SRAM widths plus the structs passed between blocks
*/
`default_nettype none

package fb_pkg;

    typedef logic [10:0] coord_t;
    typedef logic [15:0] pixel_t;
    typedef logic [19:0] sram_addr_t;
    typedef logic [17:0] sram_word_t;
    typedef logic [7:0]  drop_count_t;

    // One pixel write from ADC or SPI, x in the top bits
    typedef struct packed {
        coord_t x;
        coord_t y;
        pixel_t pixel;
    } pixel_wr_t;

    // Display pipeline read request
    typedef struct packed {
        coord_t x;
        coord_t y;
    } read_req_t;

    // Single SRAM access from arbiter to pin driver
    typedef struct packed {
        sram_addr_t addr;
        logic       write;
        sram_word_t data;
    } sram_cmd_t;

endpackage

`default_nettype wire

// File: frame_buffer_tb.sv
/*
  Frame buffer testbench
  Random pixel traffic against a reference memory, read latency and drop count checks
*/
`default_nettype none
`include "fb_macros.svh"

module frame_buffer_tb;

    localparam int DRAIN_CYCLES   = 2 * `FB_FIFO_DEPTH + 8;
    localparam int RAND_CYCLES    = 64;
    // Five tests of write, drain and read-back phases, plus slack
    localparam int TIMEOUT_CYCLES = 5 * (2 * DRAIN_CYCLES + 2 * RAND_CYCLES) + 200;

    wire                      clk;
    wire                      reset;
    logic                     frozen;
    logic                     adc_valid;
    fb_pkg::pixel_wr_t        adc_pixel;
    logic                     spi_valid;
    fb_pkg::pixel_wr_t        spi_pixel;
    logic                     read_valid;
    fb_pkg::read_req_t        read_req;
    wire                      read_data_valid;
    wire fb_pkg::pixel_t      read_data;
    wire fb_pkg::sram_addr_t  sram_addr;
    wire fb_pkg::sram_word_t  sram_data;
    wire                      sram_we_n;
    wire                      sram_ce_n;
    wire                      sram_oe_n;
    wire                      sram_adv;
    wire fb_pkg::drop_count_t adc_drop_count;
    wire fb_pkg::drop_count_t spi_drop_count;

    int                seed = 32'hdc0d_866d;
    int                cycle = 0;
    int                pixel_errors = 0;
    int                drop_errors = 0;
    int                other_errors = 0;
    string             test_name = "reset";
    // Reference memory keyed by SRAM word address
    fb_pkg::pixel_t    ref_mem [fb_pkg::sram_addr_t];
    // Outstanding reads, expected pixel and the cycle it is due
    fb_pkg::pixel_t    exp_q [$];
    int                due_q [$];
    fb_pkg::read_req_t written_q [$];
    fb_pkg::read_req_t fresh_q [$];

    tb_clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    frame_buffer_top u_dut (
        .clk             (clk),
        .reset           (reset),
        .frozen          (frozen),
        .adc_valid       (adc_valid),
        .adc_pixel       (adc_pixel),
        .spi_valid       (spi_valid),
        .spi_pixel       (spi_pixel),
        .read_valid      (read_valid),
        .read_req        (read_req),
        .read_data_valid (read_data_valid),
        .read_data       (read_data),
        .sram_addr       (sram_addr),
        .sram_data       (sram_data),
        .sram_we_n       (sram_we_n),
        .sram_ce_n       (sram_ce_n),
        .sram_oe_n       (sram_oe_n),
        .sram_adv        (sram_adv),
        .adc_drop_count  (adc_drop_count),
        .spi_drop_count  (spi_drop_count)
    );

    zbt_sram_model u_sram (
        .clk  (clk),
        .addr (sram_addr),
        .data (sram_data),
        .we_n (sram_we_n),
        .ce_n (sram_ce_n),
        .oe_n (sram_oe_n),
        .adv  (sram_adv)
    );

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic fb_pkg::pixel_t rand_pixel();
        return fb_pkg::pixel_t'($random(seed));
    endfunction

    // Low 10 bits of x above low 10 bits of y
    function automatic fb_pkg::sram_addr_t word_addr(input fb_pkg::coord_t x,
                                                     input fb_pkg::coord_t y);
        return {x[9:0], y[9:0]};
    endfunction

    function automatic logic in_view(input fb_pkg::coord_t x, input fb_pkg::coord_t y);
        return (x < `FB_X_RES) && (y < `FB_Y_RES);
    endfunction

    task automatic check_pixel(input string name, input fb_pkg::pixel_t expected,
                               input fb_pkg::pixel_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            pixel_errors++;
        end
    endtask

    task automatic check_drops(input string name, input fb_pkg::drop_count_t expected,
                               input fb_pkg::drop_count_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
            drop_errors++;
        end
    endtask

    // Falling edge, strobes back to idle
    task automatic next_cycle();
        @(negedge clk);
        adc_valid  = 1'b0;
        spi_valid  = 1'b0;
        read_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    // ADC writes only land when not frozen and in view
    task automatic send_adc(input fb_pkg::coord_t x, input fb_pkg::coord_t y,
                            input fb_pkg::pixel_t pix);
        adc_valid = 1'b1;
        adc_pixel = {x, y, pix};
        if (!frozen && in_view(x, y)) begin
            ref_mem[word_addr(x, y)] = pix;
        end
    endtask

    // kept is low for a pixel the full FIFO is expected to drop
    task automatic send_spi(input fb_pkg::coord_t x, input fb_pkg::coord_t y,
                            input fb_pkg::pixel_t pix, input logic kept);
        spi_valid = 1'b1;
        spi_pixel = {x, y, pix};
        if (kept && in_view(x, y)) begin
            ref_mem[word_addr(x, y)] = pix;
        end
    endtask

    task automatic send_read(input fb_pkg::coord_t x, input fb_pkg::coord_t y);
        fb_pkg::pixel_t expv;
        expv = '0;
        if (in_view(x, y) && ref_mem.exists(word_addr(x, y))) begin
            expv = ref_mem[word_addr(x, y)];
        end
        read_valid = 1'b1;
        read_req   = {x, y};
        exp_q.push_back(expv);
        // Sampled on the next edge, data valid 5 edges after that
        due_q.push_back(cycle + `FB_READ_LATENCY + 1);
    endtask

    task automatic wait_reads();
        while (due_q.size() != 0) begin
            next_cycle();
        end
    endtask

    // Read return monitor, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (read_data_valid === 1'b1) begin
            if (due_q.size() == 0) begin
                $display("Read data came back with no read outstanding in %s", test_name);
                other_errors++;
            end else begin
                if (due_q[0] != cycle) begin
                    $display("Read data in %s arrived at cycle %0d, due at %0d",
                             test_name, cycle, due_q[0]);
                    other_errors++;
                end
                void'(due_q.pop_front());
                check_pixel(test_name, exp_q.pop_front(), read_data);
            end
        end else if (due_q.size() != 0 && due_q[0] <= cycle) begin
            $display("Read data in %s missing at cycle %0d", test_name, cycle);
            other_errors++;
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles in %s", cycle, test_name);
            $display("Errors: pixel %0d, drop count %0d, other %0d",
                     pixel_errors, drop_errors, other_errors + 1);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        fb_pkg::read_req_t rq;
        fb_pkg::coord_t    x;
        fb_pkg::coord_t    y;
        frozen     = 1'b0;
        adc_valid  = 1'b0;
        adc_pixel  = '0;
        spi_valid  = 1'b0;
        spi_pixel  = '0;
        read_valid = 1'b0;
        read_req   = '0;
        wait (reset == 1'b1);
        wait (reset == 1'b0);

        // Random writes, ADC on even x and SPI on odd x so the two never collide
        test_name = "random_rw";
        for (int i = 0; i < RAND_CYCLES; i++) begin
            next_cycle();
            if (rand_below(4) == 0) begin
                x = fb_pkg::coord_t'(2 * rand_below(400));
                y = fb_pkg::coord_t'(rand_below(300));
                send_adc(x, y, rand_pixel());
                written_q.push_back({x, y});
            end
            if (rand_below(4) == 0) begin
                x = fb_pkg::coord_t'(2 * rand_below(400) + 1);
                y = fb_pkg::coord_t'(rand_below(300));
                send_spi(x, y, rand_pixel(), 1'b1);
                written_q.push_back({x, y});
            end
        end
        next_cycle();
        idle(DRAIN_CYCLES);
        foreach (written_q[i]) begin
            next_cycle();
            send_read(written_q[i].x, written_q[i].y);
        end
        next_cycle();
        wait_reads();
        check_drops("random_rw adc drops", '0, adc_drop_count);
        check_drops("random_rw spi drops", '0, spi_drop_count);

        // Out-of-view writes alias in-view words through the low 10 bits
        test_name = "out_of_view";
        for (int i = 0; i < 8; i++) begin
            rq = written_q[i % written_q.size()];
            next_cycle();
            send_adc(rq.x + 11'd1024, rq.y, rand_pixel());
            send_spi(rq.x, rq.y + 11'd1024, rand_pixel(), 1'b1);
        end
        next_cycle();
        idle(DRAIN_CYCLES);
        for (int i = 0; i < 8; i++) begin
            rq = written_q[i % written_q.size()];
            next_cycle();
            send_read(rq.x, rq.y);
            next_cycle();
            send_read(rq.x + 11'd1024, rq.y);
            next_cycle();
            send_read(fb_pkg::coord_t'(800 + rand_below(1248)), rq.y);
            next_cycle();
            send_read(rq.x, fb_pkg::coord_t'(600 + rand_below(1448)));
        end
        next_cycle();
        wait_reads();

        // Frozen ADC stream at full rate must still drain
        test_name = "freeze";
        next_cycle();
        frozen = 1'b1;
        for (int i = 0; i < 24; i++) begin
            rq = written_q[i % written_q.size()];
            send_adc(rq.x, rq.y, rand_pixel());
            if (i % 4 == 0) begin
                x = fb_pkg::coord_t'(rand_below(800));
                y = fb_pkg::coord_t'(300 + rand_below(100));
                send_spi(x, y, rand_pixel(), 1'b1);
                fresh_q.push_back({x, y});
            end
            next_cycle();
        end
        idle(DRAIN_CYCLES);
        check_drops("freeze adc drops", '0, adc_drop_count);
        frozen = 1'b0;
        foreach (written_q[i]) begin
            next_cycle();
            send_read(written_q[i].x, written_q[i].y);
        end
        foreach (fresh_q[i]) begin
            next_cycle();
            send_read(fresh_q[i].x, fresh_q[i].y);
        end
        next_cycle();
        wait_reads();

        // Same address from both sources in one cycle, SPI lands last
        test_name = "priority";
        fresh_q.delete();
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            x = fb_pkg::coord_t'(rand_below(800));
            y = fb_pkg::coord_t'(400 + rand_below(100));
            send_adc(x, y, rand_pixel());
            send_spi(x, y, rand_pixel(), 1'b1);
            fresh_q.push_back({x, y});
        end
        next_cycle();
        idle(DRAIN_CYCLES);
        // Back-to-back reads of stable words, an ADC write every fourth cycle
        for (int i = 0; i < 32; i++) begin
            next_cycle();
            if (i % 4 == 3) begin
                x = fb_pkg::coord_t'(rand_below(800));
                y = fb_pkg::coord_t'(500 + rand_below(80));
                send_adc(x, y, rand_pixel());
                fresh_q.push_back({x, y});
            end else begin
                rq = written_q[i % written_q.size()];
                send_read(rq.x, rq.y);
            end
        end
        next_cycle();
        idle(DRAIN_CYCLES);
        foreach (fresh_q[i]) begin
            next_cycle();
            send_read(fresh_q[i].x, fresh_q[i].y);
        end
        next_cycle();
        wait_reads();

        // SPI FIFO starved by reads, the last four pixels are dropped
        test_name = "spi_overflow";
        for (int i = 0; i < 20; i++) begin
            next_cycle();
            send_spi(fb_pkg::coord_t'(700 + i), 11'd590, rand_pixel(), 1'b1);
        end
        next_cycle();
        idle(DRAIN_CYCLES);
        for (int i = 0; i < 24; i++) begin
            next_cycle();
            rq = written_q[i % written_q.size()];
            send_read(rq.x, rq.y);
            if (i >= 2 && i < 22) begin
                send_spi(fb_pkg::coord_t'(700 + i - 2), 11'd590, rand_pixel(),
                         (i - 2) < `FB_FIFO_DEPTH);
            end
        end
        next_cycle();
        idle(DRAIN_CYCLES);
        wait_reads();
        check_drops("spi_overflow spi drops", fb_pkg::drop_count_t'(20 - `FB_FIFO_DEPTH),
                    spi_drop_count);
        check_drops("spi_overflow adc drops", '0, adc_drop_count);
        for (int i = 0; i < 20; i++) begin
            next_cycle();
            send_read(fb_pkg::coord_t'(700 + i), 11'd590);
        end
        next_cycle();
        wait_reads();

        $display("Errors: pixel %0d, drop count %0d, other %0d",
                 pixel_errors, drop_errors, other_errors);
        if (pixel_errors + drop_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: frame_buffer_top.sv
/*
  Frame buffer top
  ADC and SPI pixel FIFOs feed the arbiter, which shares one ZBT SRAM with display reads
*/
`default_nettype none

module frame_buffer_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     frozen,
    input  wire                     adc_valid,
    input  wire fb_pkg::pixel_wr_t  adc_pixel,
    input  wire                     spi_valid,
    input  wire fb_pkg::pixel_wr_t  spi_pixel,
    input  wire                     read_valid,
    input  wire fb_pkg::read_req_t  read_req,
    output wire                     read_data_valid,
    output wire fb_pkg::pixel_t     read_data,
    output wire fb_pkg::sram_addr_t sram_addr,
    inout  wire fb_pkg::sram_word_t sram_data,
    output wire                     sram_we_n,
    output wire                     sram_ce_n,
    output wire                     sram_oe_n,
    output wire                     sram_adv,
    output wire fb_pkg::drop_count_t adc_drop_count,
    output wire fb_pkg::drop_count_t spi_drop_count
);

    // FIFO heads towards the arbiter
    wire                     adc_not_empty;
    wire                     spi_not_empty;
    wire fb_pkg::pixel_wr_t  adc_head;
    wire fb_pkg::pixel_wr_t  spi_head;
    wire                     adc_pop;
    wire                     spi_pop;
    // Arbiter to pin driver
    wire                     cmd_valid;
    wire fb_pkg::sram_cmd_t  cmd;
    wire fb_pkg::sram_word_t rd_word;

    pixel_fifo u_adc_fifo (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (adc_valid),
        .in_pixel   (adc_pixel),
        .pop        (adc_pop),
        .not_empty  (adc_not_empty),
        .head       (adc_head),
        .drop_count (adc_drop_count)
    );

    pixel_fifo u_spi_fifo (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (spi_valid),
        .in_pixel   (spi_pixel),
        .pop        (spi_pop),
        .not_empty  (spi_not_empty),
        .head       (spi_head),
        .drop_count (spi_drop_count)
    );

    fb_arbiter u_arbiter (
        .clk             (clk),
        .reset           (reset),
        .frozen          (frozen),
        .read_valid      (read_valid),
        .read_req        (read_req),
        .adc_not_empty   (adc_not_empty),
        .spi_not_empty   (spi_not_empty),
        .adc_head        (adc_head),
        .spi_head        (spi_head),
        .adc_pop         (adc_pop),
        .spi_pop         (spi_pop),
        .cmd_valid       (cmd_valid),
        .cmd             (cmd),
        .rd_word         (rd_word),
        .read_data_valid (read_data_valid),
        .read_data       (read_data)
    );

    sram_port u_sram_port (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .rd_word   (rd_word),
        .sram_addr (sram_addr),
        .sram_data (sram_data),
        .sram_we_n (sram_we_n),
        .sram_ce_n (sram_ce_n),
        .sram_oe_n (sram_oe_n),
        .sram_adv  (sram_adv)
    );

endmodule

`default_nettype wire

// File: list.f
+incdir+.
fb_pkg.sv
pixel_fifo.sv
fb_arbiter.sv
sram_port.sv
frame_buffer_top.sv
tb_clock_gen.sv
zbt_sram_model.sv
frame_buffer_tb.sv

// File: pixel_fifo.sv
/*
  Pixel FIFO, show-ahead
  Head is visible while not_empty, pushes into a full buffer are dropped and counted
*/
`default_nettype none
`include "fb_macros.svh"

module pixel_fifo #(
    parameter int DEPTH = `FB_FIFO_DEPTH
) (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  in_valid,
    input  wire fb_pkg::pixel_wr_t in_pixel,
    input  wire                  pop,
    output logic                 not_empty,
    output fb_pkg::pixel_wr_t    head,
    output fb_pkg::drop_count_t  drop_count
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fb_pkg::pixel_wr_t mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;
    logic              do_pop;
    logic              do_push;
    logic              drop;

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    // Pop only counts when something is there
    assign do_pop  = pop && not_empty;
    // Full but popping this cycle still frees a slot
    assign do_push = in_valid && (!full || do_pop);
    assign drop    = in_valid && !do_push;

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= in_pixel;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            drop_count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Occupancy holds on push+pop
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            // Saturates at all ones
            if (drop && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: sram_port.sv
/*
  ZBT SRAM pin driver
  Puts commands on the pins, drives write data in the data phase
  and captures read data from the bus
*/
`default_nettype none
`include "fb_macros.svh"

module sram_port (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     cmd_valid,
    input  wire fb_pkg::sram_cmd_t  cmd,
    output fb_pkg::sram_word_t      rd_word,
    output fb_pkg::sram_addr_t      sram_addr,
    inout  wire fb_pkg::sram_word_t sram_data,
    output logic                    sram_we_n,
    output logic                    sram_ce_n,
    output logic                    sram_oe_n,
    output logic                    sram_adv
);

    localparam int PIPE = `FB_SRAM_PIPE;

    // Stage 0 lines up with the address on the pins, stage PIPE is the data phase
    logic [PIPE:0]      ph_valid;
    logic [PIPE:0]      ph_write;
    fb_pkg::sram_word_t wd_pipe [PIPE+1];
    logic               drive_bus;
    logic               read_phase;

    assign drive_bus  = ph_valid[PIPE] && ph_write[PIPE];
    assign read_phase = ph_valid[PIPE] && !ph_write[PIPE];

    // Bus is ours only while a write is in its data phase
    assign sram_data = drive_bus ? wd_pipe[PIPE] : 'z;
    // SRAM output enable for a read's data phase
    assign sram_oe_n = !read_phase;

    // Pins and phase tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            sram_we_n <= 1'b1;
            sram_ce_n <= 1'b1;
            sram_adv  <= 1'b1;
            ph_valid  <= '0;
            ph_write  <= '0;
        end else begin
            sram_we_n <= !(cmd_valid && cmd.write);
            sram_ce_n <= !cmd_valid;
            // Low loads a new address
            sram_adv  <= !cmd_valid;
            ph_valid  <= {ph_valid[PIPE-1:0], cmd_valid};
            ph_write  <= {ph_write[PIPE-1:0], cmd.write};
        end
    end

    // Address and write data delay line
    always_ff @(posedge clk) begin
        sram_addr  <= cmd.addr;
        wd_pipe[0] <= cmd.data;
        for (int i = 1; i <= PIPE; i++) begin
            wd_pipe[i] <= wd_pipe[i-1];
        end
    end

    // Read capture at the end of the data phase
    always_ff @(posedge clk) begin
        if (read_phase) begin
            rd_word <= sram_data;
        end
    end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
/*
  Testbench clock and reset
  Period of 100 with reset held over the first two rising edges
*/
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        // Reset drops on a falling edge
        @(negedge clk);
        reset = 1'b0;
    end

    always #50 clk = ~clk;

endmodule

`default_nettype wire

// File: zbt_sram_model.sv
/*
  Behavioural ZBT SRAM
  Address and control sampled on the rising edge, data phase FB_SRAM_PIPE cycles later
*/
`default_nettype none
`include "fb_macros.svh"

module zbt_sram_model (
    input  wire                     clk,
    input  wire fb_pkg::sram_addr_t addr,
    inout  wire fb_pkg::sram_word_t data,
    input  wire                     we_n,
    input  wire                     ce_n,
    input  wire                     oe_n,
    input  wire                     adv
);

    localparam int PIPE = `FB_SRAM_PIPE;

    // Unwritten words read as zero
    fb_pkg::sram_word_t mem [fb_pkg::sram_addr_t];
    // Stage PIPE-1 is the data phase
    logic [PIPE-1:0]    st_valid = '0;
    logic [PIPE-1:0]    st_write = '0;
    fb_pkg::sram_addr_t st_addr [PIPE];
    fb_pkg::sram_word_t rd_word;
    logic               drive;

    assign drive = st_valid[PIPE-1] && !st_write[PIPE-1] && !oe_n;
    assign data  = drive ? rd_word : 'z;

    always @(posedge clk) begin
        // Write commits at the end of its data phase, before the next read looks
        if (st_valid[PIPE-1] && st_write[PIPE-1]) begin
            mem[st_addr[PIPE-1]] = data;
        end
        // Read word for the data phase that starts now
        if (mem.exists(st_addr[PIPE-2])) begin
            rd_word <= mem[st_addr[PIPE-2]];
        end else begin
            rd_word <= '0;
        end
        // New access only with chip enabled and address load low
        st_valid   <= {st_valid[PIPE-2:0], !ce_n && !adv};
        st_write   <= {st_write[PIPE-2:0], !we_n};
        st_addr[0] <= addr;
        for (int i = 1; i < PIPE; i++) begin
            st_addr[i] <= st_addr[i-1];
        end
    end

endmodule

`default_nettype wire
